//--- hw/capture_pkg.sv
`default_nettype none

package capture_pkg;

  // One capture record from the DDR capture logic
  typedef logic [63:0] cap_word_t;

  // Half of a record, which is what one bus word holds
  typedef logic [31:0] cap_half_t;

  // 64 entries unless the top level says otherwise
  localparam int INDEX_W_DEFAULT = 6;

endpackage

`default_nettype wire

//--- hw/wb_pkg.sv
`default_nettype none

package wb_pkg;

  // Bus data word
  typedef logic [31:0] wb_data_t;

  // Byte lanes of the 32-bit bus
  typedef logic [3:0] wb_sel_t;

endpackage

`default_nettype wire

//--- hw/dual_clock_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_clock_ram #(
  parameter int ADDR_W = 6,
  parameter int DATA_W = 32
) (
  input  wire               wr_clk_i,
  input  wire               wr_en_i,
  input  wire  [ADDR_W-1:0] wr_addr_i,
  input  wire  [DATA_W-1:0] wr_data_i,
  input  wire               rd_clk_i,
  input  wire               rd_en_i,
  input  wire  [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // Write port, capture side
  always_ff @(posedge wr_clk_i)
  begin
    if (wr_en_i)
    begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Read port, bus side
  always_ff @(posedge rd_clk_i)
  begin
    if (rd_en_i)
    begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

  a_wr_addr_known: assert property (
    @(posedge wr_clk_i) wr_en_i |-> !$isunknown(wr_addr_i)
  )
  else
    $error("dual_clock_ram: write with unknown address at %0t", $time);

endmodule

`default_nettype wire

//--- hw/capture_index_writer.sv
`timescale 1ns/1ps
`default_nettype none

module capture_index_writer #(
  parameter int INDEX_W = capture_pkg::INDEX_W_DEFAULT
) (
  input  wire                    cap_clk_i,
  input  wire                    rst_n_i,
  input  wire                    cap_valid_i,
  input  wire capture_pkg::cap_word_t cap_data_i,
  input  wire                    cap_oneshot_i,
  output logic [INDEX_W-1:0]     cap_index_o,
  output logic                   cap_full_o,
  output logic                   ram_we_o,
  output logic [INDEX_W-1:0]     ram_addr_o,
  output capture_pkg::cap_word_t ram_data_o
);

  typedef logic [INDEX_W-1:0] index_t;

  typedef enum logic
  {
    WR_RUN,
    WR_FULL
  } wr_state_t;

  localparam index_t LAST_INDEX = {INDEX_W{1'b1}};

  logic [1:0] rst_sync;
  logic       cap_rst_n;
  index_t     wr_ptr;
  wr_state_t  state;
  logic       wr_fire;
  logic       last_entry;

  // Bus reset brought into the capture clock
  always_ff @(posedge cap_clk_i)
  begin
    rst_sync <= {rst_sync[0], rst_n_i};
  end

  assign cap_rst_n = rst_sync[1];

  assign cap_full_o = (state == WR_FULL);
  assign wr_fire = cap_valid_i && !cap_full_o;
  assign last_entry = (wr_ptr == LAST_INDEX);

  always_ff @(posedge cap_clk_i)
  begin
    if (!cap_rst_n)
    begin
      wr_ptr <= '0;
      state  <= WR_RUN;
    end
    else
    begin
      // Pointer wraps by overflow of the index width
      if (wr_fire)
        wr_ptr <= wr_ptr + 1'b1;

      case (state)
        WR_RUN:
        begin
          if (wr_fire && cap_oneshot_i && last_entry)
            state <= WR_FULL;
        end
        WR_FULL:
        begin
          // Dropping one-shot rearms the writer
          if (!cap_oneshot_i)
            state <= WR_RUN;
        end
        default:
          state <= WR_RUN;
      endcase
    end
  end

  assign cap_index_o = wr_ptr;
  assign ram_we_o    = wr_fire;
  assign ram_addr_o  = wr_ptr;
  assign ram_data_o  = cap_data_i;

  a_hold_when_full: assert property (
    @(posedge cap_clk_i) disable iff (!cap_rst_n)
    cap_full_o |=> $stable(wr_ptr)
  )
  else
    $error("capture_index_writer: pointer moved while full at %0t", $time);

endmodule

`default_nettype wire

//--- hw/capture_index_mem.sv
`timescale 1ns/1ps
`default_nettype none

module capture_index_mem #(
  parameter int INDEX_W = capture_pkg::INDEX_W_DEFAULT
) (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire  [INDEX_W+2:2]     wb_adr_i,
  output logic                   wb_ack_o,
  output logic                   wb_stall_o,
  output wb_pkg::wb_data_t       wb_dat_o,
  input  wire                    cap_clk_i,
  input  wire                    ram_we_i,
  input  wire  [INDEX_W-1:0]     ram_addr_i,
  input  wire capture_pkg::cap_word_t ram_data_i
);

  import capture_pkg::*;
  import wb_pkg::*;

  logic               wb_en;
  logic               rd_req;
  logic               wr_req;
  logic               wb_rip;
  logic               wb_wip;
  logic               rd_ack;
  logic               wr_ack;
  logic               wr_req_d0;
  logic               rd_ack_d0;
  wb_data_t           rd_dat_d0;
  logic               word_sel;
  logic [INDEX_W-1:0] entry_adr;

  // Index 0 is the upper half (even word), index 1 the lower half
  logic [1:0]         rreq;
  logic [1:0]         rack;

  cap_half_t          ram_hi_wdata;
  cap_half_t          ram_lo_wdata;
  wb_data_t           ram_hi_rdata;
  wb_data_t           ram_lo_rdata;

  assign wb_en     = wb_cyc_i & wb_stb_i;
  assign word_sel  = wb_adr_i[2];
  assign entry_adr = wb_adr_i[INDEX_W+2:3];

  // New transfer only when none of that kind is in flight
  assign rd_req = wb_en & ~wb_we_i & ~wb_rip;
  assign wr_req = wb_en & wb_we_i & ~wb_wip;

  // Writes go nowhere, ack one cycle later
  assign wr_ack = wr_req_d0;

  assign wb_ack_o   = rd_ack | wr_ack;
  assign wb_stall_o = wb_en & ~wb_ack_o;

  always_comb
  begin
    rreq = '0;
    rreq[word_sel] = rd_req;
    rd_ack_d0 = rack[word_sel];
    rd_dat_d0 = word_sel ? ram_lo_rdata : ram_hi_rdata;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wb_rip    <= 1'b0;
      wb_wip    <= 1'b0;
      rack      <= '0;
      rd_ack    <= 1'b0;
      wr_req_d0 <= 1'b0;
      wb_dat_o  <= '0;
    end
    else
    begin
      wb_rip    <= (wb_rip | (wb_en & ~wb_we_i)) & ~rd_ack;
      wb_wip    <= (wb_wip | (wb_en & wb_we_i)) & ~wr_ack;
      rack      <= rreq;
      rd_ack    <= rd_ack_d0;
      wr_req_d0 <= wr_req;
      // Output word only moves on a read ack
      if (rd_ack_d0)
        wb_dat_o <= rd_dat_d0;
    end
  end

  assign ram_hi_wdata = ram_data_i[63:32];
  assign ram_lo_wdata = ram_data_i[31:0];

  dual_clock_ram #(
    .ADDR_W (INDEX_W),
    .DATA_W ($bits(wb_data_t))
  ) u_ram_hi (
    .wr_clk_i  (cap_clk_i),
    .wr_en_i   (ram_we_i),
    .wr_addr_i (ram_addr_i),
    .wr_data_i (ram_hi_wdata),
    .rd_clk_i  (clk_i),
    .rd_en_i   (rreq[0]),
    .rd_addr_i (entry_adr),
    .rd_data_o (ram_hi_rdata)
  );

  dual_clock_ram #(
    .ADDR_W (INDEX_W),
    .DATA_W ($bits(wb_data_t))
  ) u_ram_lo (
    .wr_clk_i  (cap_clk_i),
    .wr_en_i   (ram_we_i),
    .wr_addr_i (ram_addr_i),
    .wr_data_i (ram_lo_wdata),
    .rd_clk_i  (clk_i),
    .rd_en_i   (rreq[1]),
    .rd_addr_i (entry_adr),
    .rd_data_o (ram_lo_rdata)
  );

  // An ack always closes a transfer that is in flight
  a_ack_in_flight: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> (wb_rip || wb_wip)
  )
  else
    $error("capture_index_mem: ack without a transfer in flight at %0t", $time);

  a_ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(wb_ack_o) |-> wb_cyc_i
  )
  else
    $error("capture_index_mem: ack outside a bus cycle at %0t", $time);

endmodule

`default_nettype wire

//--- hw/ddr_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_capture_top #(
  parameter int INDEX_W = capture_pkg::INDEX_W_DEFAULT
) (
  input  wire                         clk_i,
  input  wire                         cap_clk_i,
  input  wire                         rst_n_i,

  // Wishbone slave, pipelined
  input  wire                         wb_cyc_i,
  input  wire                         wb_stb_i,
  input  wire                         wb_we_i,
  input  wire  [INDEX_W+2:2]          wb_adr_i,
  input  wire wb_pkg::wb_sel_t        wb_sel_i,
  input  wire wb_pkg::wb_data_t       wb_dat_i,
  output wire                         wb_ack_o,
  output wire                         wb_stall_o,
  output wire wb_pkg::wb_data_t       wb_dat_o,

  // Capture side
  input  wire                         cap_valid_i,
  input  wire capture_pkg::cap_word_t cap_data_i,
  input  wire                         cap_oneshot_i,
  output wire  [INDEX_W-1:0]          cap_index_o,
  output wire                         cap_full_o
);

  import capture_pkg::*;

  wire               ram_we;
  wire [INDEX_W-1:0] ram_addr;
  cap_word_t         ram_data;

  // wb_sel_i and wb_dat_i stay on the port list only; the bus never writes

  capture_index_writer #(
    .INDEX_W (INDEX_W)
  ) u_writer (
    .cap_clk_i     (cap_clk_i),
    .rst_n_i       (rst_n_i),
    .cap_valid_i   (cap_valid_i),
    .cap_data_i    (cap_data_i),
    .cap_oneshot_i (cap_oneshot_i),
    .cap_index_o   (cap_index_o),
    .cap_full_o    (cap_full_o),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_data_o    (ram_data)
  );

  capture_index_mem #(
    .INDEX_W (INDEX_W)
  ) u_mem (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_ack_o   (wb_ack_o),
    .wb_stall_o (wb_stall_o),
    .wb_dat_o   (wb_dat_o),
    .cap_clk_i  (cap_clk_i),
    .ram_we_i   (ram_we),
    .ram_addr_i (ram_addr),
    .ram_data_i (ram_data)
  );

endmodule

`default_nettype wire

//--- bench/ddr_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_capture_tb;

  import capture_pkg::*;
  import wb_pkg::*;

  localparam int INDEX_W      = 6;
  localparam int DEPTH        = 2 ** INDEX_W;
  localparam int ACK_TIMEOUT  = 16;
  localparam int FULL_TIMEOUT = 32;

  logic                 clk_i;
  logic                 cap_clk_i;
  logic                 rst_n_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [INDEX_W+2:2]   wb_adr_i;
  wb_sel_t              wb_sel_i;
  wb_data_t             wb_dat_i;
  logic                 wb_ack_o;
  logic                 wb_stall_o;
  wb_data_t             wb_dat_o;
  logic                 cap_valid_i;
  cap_word_t            cap_data_i;
  logic                 cap_oneshot_i;
  logic [INDEX_W-1:0]   cap_index_o;
  logic                 cap_full_o;

  integer               seed;
  logic                 reset_chk;
  wb_data_t             exp_data;

  // Reference model of the capture memory
  cap_word_t            model_mem [DEPTH];
  logic [INDEX_W-1:0]   model_index;
  logic                 model_full;

  ddr_capture_top #(
    .INDEX_W (INDEX_W)
  ) u_ddr_capture_top (
    .clk_i         (clk_i),
    .cap_clk_i     (cap_clk_i),
    .rst_n_i       (rst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_sel_i      (wb_sel_i),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_o      (wb_ack_o),
    .wb_stall_o    (wb_stall_o),
    .wb_dat_o      (wb_dat_o),
    .cap_valid_i   (cap_valid_i),
    .cap_data_i    (cap_data_i),
    .cap_oneshot_i (cap_oneshot_i),
    .cap_index_o   (cap_index_o),
    .cap_full_o    (cap_full_o)
  );

  always #5 clk_i = ~clk_i;

  // Edges never line up with the bus clock
  always #4 cap_clk_i = ~cap_clk_i;

  // Store and advance unless full, one-shot stops at the last entry
  always @(posedge cap_clk_i)
  begin
    if (!rst_n_i)
    begin
      model_index <= '0;
      model_full  <= 1'b0;
    end
    else if (model_full)
    begin
      if (!cap_oneshot_i)
        model_full <= 1'b0;
    end
    else if (cap_valid_i)
    begin
      model_mem[model_index] <= cap_data_i;
      model_index            <= model_index + 1'b1;
      if (cap_oneshot_i && (model_index == INDEX_W'(DEPTH - 1)))
        model_full <= 1'b1;
    end
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  a_reset_values: assert property (
    @(posedge clk_i) reset_chk |->
      !wb_ack_o && !wb_stall_o && !cap_full_o && (cap_index_o == '0) && (wb_dat_o == '0)
  )
  else
    stop_with_failure($sformatf("CHECK FAILED at %0t: outputs not at reset values", $time));

  a_read_timing: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ($rose(wb_stb_i) && wb_cyc_i && !wb_we_i) |->
      (wb_stall_o && !wb_ack_o) ##1 (wb_stall_o && !wb_ack_o)
      ##1 (wb_ack_o && !wb_stall_o) ##1 !wb_ack_o
  )
  else
    stop_with_failure($sformatf("CHECK FAILED at %0t: read ack/stall timing wrong", $time));

  a_write_timing: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ($rose(wb_stb_i) && wb_cyc_i && wb_we_i) |->
      (wb_stall_o && !wb_ack_o) ##1 (wb_ack_o && !wb_stall_o) ##1 !wb_ack_o
  )
  else
    stop_with_failure($sformatf("CHECK FAILED at %0t: write ack/stall timing wrong", $time));

  a_ack_needs_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !wb_cyc_i |-> !wb_ack_o
  )
  else
    stop_with_failure($sformatf("CHECK FAILED at %0t: ack outside a bus cycle", $time));

  a_read_data: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (wb_ack_o && !wb_we_i) |-> (wb_dat_o == exp_data)
  )
  else
    stop_with_failure($sformatf("CHECK FAILED at %0t: read data %h, expected %h",
                                $time, $sampled(wb_dat_o), $sampled(exp_data)));

  a_writer_state: assert property (
    @(posedge cap_clk_i) disable iff (!rst_n_i)
    (cap_index_o == model_index) && (cap_full_o == model_full)
  )
  else
    stop_with_failure($sformatf("CHECK FAILED at %0t: index %0d full %0b, expected %0d %0b",
                                $time, $sampled(cap_index_o), $sampled(cap_full_o),
                                $sampled(model_index), $sampled(model_full)));

  a_full_holds: assert property (
    @(posedge cap_clk_i) disable iff (!rst_n_i)
    (cap_full_o && cap_valid_i) |=> $stable(cap_index_o)
  )
  else
    stop_with_failure($sformatf("CHECK FAILED at %0t: index moved while full", $time));

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Capture side leaves reset two capture clocks later
    repeat (3) @(posedge clk_i);
    reset_chk <= 1'b1;
    repeat (2) @(posedge clk_i);
    reset_chk <= 1'b0;
  endtask

  task automatic push_records(input int count);
    int n;
    for (n = 0; n < count; n++)
    begin
      @(posedge cap_clk_i);
      cap_valid_i <= 1'b1;
      cap_data_i  <= {$random(seed), $random(seed)};
    end
    @(posedge cap_clk_i);
    cap_valid_i <= 1'b0;
    // Data path has no synchronizer, let it settle
    repeat (3) @(posedge clk_i);
  endtask

  task automatic await_ack(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!wb_ack_o && (cycles < ACK_TIMEOUT))
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (!wb_ack_o)
      stop_with_failure($sformatf("No bus ack for a %s within %0d cycles", what, ACK_TIMEOUT));
  endtask

  task automatic await_full(input logic level);
    int cycles;
    cycles = 0;
    @(negedge cap_clk_i);
    while ((cap_full_o !== level) && (cycles < FULL_TIMEOUT))
    begin
      @(negedge cap_clk_i);
      cycles++;
    end
    if (cap_full_o !== level)
      stop_with_failure($sformatf("cap_full_o never went to %0b within %0d capture cycles",
                                  level, FULL_TIMEOUT));
  endtask

  task automatic read_word(input logic [INDEX_W-1:0] entry, input logic lower);
    @(posedge clk_i);
    exp_data <= lower ? model_mem[entry][31:0] : model_mem[entry][63:32];
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= {entry, lower};
    await_ack("read");
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic write_word(input logic [INDEX_W-1:0] entry, input logic lower,
                            input wb_data_t data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= {entry, lower};
    wb_sel_i <= 4'hf;
    wb_dat_i <= data;
    await_ack("write");
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic check_entry(input logic [INDEX_W-1:0] entry);
    read_word(entry, 1'b0);
    read_word(entry, 1'b1);
  endtask

  initial
  begin
    int e;
    clk_i         = 1'b0;
    cap_clk_i     = 1'b0;
    rst_n_i       = 1'b0;
    reset_chk     = 1'b0;
    exp_data      = '0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_sel_i      = '0;
    wb_dat_i      = '0;
    cap_valid_i   = 1'b0;
    cap_data_i    = '0;
    cap_oneshot_i = 1'b0;
    seed          = 32'hb44e_2d1b;

    apply_reset();

    // Ten records, both words of each
    push_records(10);
    for (e = 0; e < 10; e++)
      check_entry(INDEX_W'(e));

    // Bus writes are acked and dropped
    write_word(INDEX_W'(3), 1'b1, $random(seed));
    read_word(INDEX_W'(3), 1'b1);
    write_word(INDEX_W'(7), 1'b0, $random(seed));
    read_word(INDEX_W'(7), 1'b0);

    // Wrap mode, newest records land in entries 0 to 4
    apply_reset();
    push_records(DEPTH + 5);
    @(negedge clk_i);
    a_wrap_index: assert (cap_index_o == INDEX_W'(5))
    else
      stop_with_failure($sformatf("CHECK FAILED at %0t: index %0d after wrap, expected 5",
                                  $time, cap_index_o));
    for (e = 0; e < DEPTH; e++)
      check_entry(INDEX_W'(e));

    // One-shot mode
    apply_reset();
    @(posedge cap_clk_i);
    cap_oneshot_i <= 1'b1;
    push_records(DEPTH);
    await_full(1'b1);
    push_records(3);
    check_entry(INDEX_W'(0));
    check_entry(INDEX_W'(31));
    check_entry(INDEX_W'(DEPTH - 1));
    @(posedge cap_clk_i);
    cap_oneshot_i <= 1'b0;
    await_full(1'b0);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- ddr_capture.f
hw/capture_pkg.sv
hw/wb_pkg.sv
hw/dual_clock_ram.sv
hw/capture_index_writer.sv
hw/capture_index_mem.sv
hw/ddr_capture_top.sv
bench/ddr_capture_tb.sv
